// ==== lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// width of a byte address.
// the data memory holds 2**LSU_ADDR_WIDTH bytes.
`define LSU_ADDR_WIDTH 8

// default cycle limit for a simulation run.
`define LSU_TIMEOUT_CYCLES 2000

`endif

// ==== lsu_pkg.sv ====
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_WIDTH-1:0] lsu_addr_t;
    typedef logic [31:0]                lsu_word_t;
    typedef logic [3:0]                 lsu_mask_t;   // bit k selects lane k.
    typedef logic [1:0]                 lsu_size_t;
    typedef logic [1:0]                 lsu_offset_t; // byte within the word.

    localparam lsu_size_t SIZE_BYTE = 2'd0;
    localparam lsu_size_t SIZE_HALF = 2'd1;
    localparam lsu_size_t SIZE_WORD = 2'd2;

    // request as issued by the processor.
    typedef struct packed {
        logic       store;
        lsu_size_t  size;
        logic       is_unsigned;
        lsu_addr_t  addr;
        lsu_word_t  data;
    } lsu_req_t;

    // record passed between the stages.
    typedef struct packed {
        logic        store;
        logic        is_unsigned;
        lsu_size_t   size;
        logic        misaligned;
        lsu_addr_t   base;
        lsu_offset_t offset;
        lsu_mask_t   mask;
        lsu_word_t   lanes;   // store data in, read bytes out.
    } lsu_acc_t;

    typedef struct packed {
        logic       store;
        logic       misaligned;
        lsu_word_t  data;
    } lsu_rsp_t;

endpackage

`default_nettype wire

// ==== lsu_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_align (
    input  logic               CLK,
    input  logic               rst,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               acc_valid,
    output lsu_pkg::lsu_acc_t  acc,
    input  logic               acc_ready
);

    lsu_pkg::lsu_acc_t     acc_next;
    lsu_pkg::lsu_offset_t  offset;
    logic                  accept;

    assign offset    = req.addr[1:0];
    assign req_ready = !acc_valid || acc_ready;   // empty or draining.
    assign accept    = req_valid && req_ready;

    always_comb begin
        acc_next             = '0;
        acc_next.store       = req.store;
        acc_next.is_unsigned = req.is_unsigned;
        acc_next.size        = req.size;
        acc_next.base        = req.addr & ~lsu_pkg::lsu_addr_t'(2'b11);
        acc_next.offset      = offset;

        case (req.size)
            lsu_pkg::SIZE_BYTE: begin
                acc_next.mask  = 4'b1000 >> offset;
                acc_next.lanes = {24'h0, req.data[7:0]} << {2'd3 - offset, 3'b000};
            end
            lsu_pkg::SIZE_HALF: begin
                if (offset == 2'd0) begin
                    acc_next.mask  = 4'b1100;
                    acc_next.lanes = {req.data[15:0], 16'h0};
                end else if (offset == 2'd2) begin
                    acc_next.mask  = 4'b0011;
                    acc_next.lanes = {16'h0, req.data[15:0]};
                end else begin
                    acc_next.misaligned = 1'b1;   // odd halfword.
                end
            end
            lsu_pkg::SIZE_WORD: begin
                if (offset == 2'd0) begin
                    acc_next.mask  = 4'b1111;
                    acc_next.lanes = req.data;    // bits 31:24 land at the base.
                end else begin
                    acc_next.misaligned = 1'b1;
                end
            end
            default: begin
                acc_next.misaligned = 1'b1;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else if (accept) begin
            acc_valid <= 1'b1;
        end else if (acc_ready) begin
            acc_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            acc <= acc_next;
        end
    end

    // a legal access is a byte, a halfword or a full word.
    a_mask_legal: assert property (@(posedge CLK) disable iff (rst)
        acc_valid && !acc.misaligned |-> $countones(acc.mask) inside {1, 2, 4});

endmodule

`default_nettype wire

// ==== lsu_byte_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_byte_memory (
    input  logic               CLK,
    input  logic               rst,
    input  logic               acc_valid,
    input  lsu_pkg::lsu_acc_t  acc,
    output logic               acc_ready,
    output logic               done_valid,
    output lsu_pkg::lsu_acc_t  done,
    input  logic               done_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LANE,
        ST_FINISH
    } state_t;

    localparam int DEPTH = 2 ** `LSU_ADDR_WIDTH;

    logic [7:0] mem [0:DEPTH-1];

    state_t              state;
    lsu_pkg::lsu_mask_t  remaining;       // lanes still to access.
    lsu_pkg::lsu_mask_t  remaining_next;
    logic [1:0]          lane;
    lsu_pkg::lsu_addr_t  lane_addr;
    logic                accept;

    assign acc_ready  = (state == ST_IDLE);
    assign done_valid = (state == ST_FINISH);
    assign accept     = acc_valid && acc_ready;

    // highest set lane goes first.
    always_comb begin
        lane = 2'd0;
        for (int k = 0; k < 4; k++) begin
            if (remaining[k]) begin
                lane = 2'(k);
            end
        end
    end

    // lane k sits at base + 3 - k.
    assign lane_addr      = {done.base[`LSU_ADDR_WIDTH-1:2], 2'd3 - lane};
    assign remaining_next = remaining & ~(4'b0001 << lane);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= ST_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (acc_valid) begin
                        remaining <= acc.mask;
                        if (acc.misaligned || acc.mask == '0) begin
                            state <= ST_FINISH;   // nothing to touch.
                        end else begin
                            state <= ST_LANE;
                        end
                    end
                end
                ST_LANE: begin
                    remaining <= remaining_next;
                    if (remaining_next == '0) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    if (done_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // read bytes fill the record register lane by lane.
    always_ff @(posedge CLK) begin
        if (accept) begin
            done <= acc;
            if (!acc.store) begin
                done.lanes <= '0;   // untouched lanes of a load read as zero.
            end
        end else if (state == ST_LANE && !done.store) begin
            done.lanes[8*lane +: 8] <= mem[lane_addr];
        end
    end

    always_ff @(posedge CLK) begin
        if (state == ST_LANE && done.store) begin
            mem[lane_addr] <= done.lanes[8*lane +: 8];
        end
    end

    // one access at a time until the result has been handed on.
    a_one_in_flight: assert property (@(posedge CLK) disable iff (rst)
        acc_valid && acc_ready |=> !acc_ready until (done_valid && done_ready));

    a_done_hold: assert property (@(posedge CLK) disable iff (rst)
        done_valid && !done_ready |=> done_valid && $stable(done));

endmodule

`default_nettype wire

// ==== lsu_load_format.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_load_format (
    input  logic               CLK,
    input  logic               rst,
    input  logic               done_valid,
    input  lsu_pkg::lsu_acc_t  done,
    output logic               done_ready,
    output logic               rsp_valid,
    output lsu_pkg::lsu_rsp_t  rsp,
    input  logic               rsp_ready
);

    lsu_pkg::lsu_rsp_t   rsp_next;
    lsu_pkg::lsu_word_t  shifted;
    logic [4:0]          shift;
    logic                accept;

    assign done_ready = !rsp_valid || rsp_ready;
    assign accept     = done_valid && done_ready;

    // distance from the selected lanes down to bit 0.
    always_comb begin
        case (done.size)
            lsu_pkg::SIZE_BYTE: shift = {2'd3 - done.offset, 3'b000};
            lsu_pkg::SIZE_HALF: shift = {2'd2 - done.offset, 3'b000};
            default:            shift = 5'd0;
        endcase
    end

    assign shifted = done.lanes >> shift;

    always_comb begin
        rsp_next            = '0;
        rsp_next.store      = done.store;
        rsp_next.misaligned = done.misaligned;
        if (!done.store && !done.misaligned) begin
            case (done.size)
                lsu_pkg::SIZE_BYTE: begin
                    rsp_next.data = done.is_unsigned ? {24'h0, shifted[7:0]}
                                                     : {{24{shifted[7]}}, shifted[7:0]};
                end
                lsu_pkg::SIZE_HALF: begin
                    rsp_next.data = done.is_unsigned ? {16'h0, shifted[15:0]}
                                                     : {{16{shifted[15]}}, shifted[15:0]};
                end
                default: begin
                    rsp_next.data = shifted;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            rsp <= rsp_next;
        end
    end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  logic               CLK,
    input  logic               rst,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               rsp_valid,
    output lsu_pkg::lsu_rsp_t  rsp,
    input  logic               rsp_ready
);

    logic               acc_valid;
    logic               acc_ready;
    lsu_pkg::lsu_acc_t  acc;

    logic               done_valid;
    logic               done_ready;
    lsu_pkg::lsu_acc_t  done;   // lanes carry the read bytes.

    lsu_align align_i (
        .CLK       (CLK),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .acc_valid (acc_valid),
        .acc       (acc),
        .acc_ready (acc_ready)
    );

    lsu_byte_memory memory_i (
        .CLK        (CLK),
        .rst        (rst),
        .acc_valid  (acc_valid),
        .acc        (acc),
        .acc_ready  (acc_ready),
        .done_valid (done_valid),
        .done       (done),
        .done_ready (done_ready)
    );

    lsu_load_format format_i (
        .CLK        (CLK),
        .rst        (rst),
        .done_valid (done_valid),
        .done       (done),
        .done_ready (done_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready)
    );

endmodule

`default_nettype wire

// ==== lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

    typedef struct packed {
        lsu_pkg::lsu_req_t  req;
        lsu_pkg::lsu_rsp_t  rsp;   // expected response.
    } entry_t;

    logic               CLK;
    logic               rst;
    logic               req_valid;
    lsu_pkg::lsu_req_t  req;
    logic               req_ready;
    logic               rsp_valid;
    lsu_pkg::lsu_rsp_t  rsp;
    logic               rsp_ready;

    entry_t             stim_table[$];
    lsu_pkg::lsu_rsp_t  expect_q[$];
    logic [7:0]         ref_mem [0:(2 ** `LSU_ADDR_WIDTH)-1];
    logic [31:0]        rng = 32'h7fcc;
    int                 accepted = 0;
    int                 received = 0;
    int                 value_errors = 0;
    int                 protocol_errors = 0;
    int                 cycles = 0;
    int                 cycle_limit = `LSU_TIMEOUT_CYCLES;

    lsu_top dut_i (
        .CLK       (CLK),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h (response %0d)",
                     name, expected, actual, received);
            value_errors++;
        end
    endtask

    // byte-array model with the byte at the lowest address most significant.
    task automatic model_access(input lsu_pkg::lsu_req_t r, output lsu_pkg::lsu_rsp_t p);
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        logic        bad;
        a   = r.addr;
        bad = (r.size == 2'd3) ||
              (r.size == lsu_pkg::SIZE_HALF && a % 2 != 0) ||
              (r.size == lsu_pkg::SIZE_WORD && a % 4 != 0);
        p            = '0;
        p.store      = r.store;
        p.misaligned = bad;
        if (!bad && r.store) begin
            if (r.size == lsu_pkg::SIZE_BYTE) begin
                ref_mem[a] = r.data[7:0];
            end else if (r.size == lsu_pkg::SIZE_HALF) begin
                ref_mem[a]     = r.data[15:8];
                ref_mem[a + 1] = r.data[7:0];
            end else begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[a + k] = r.data[31 - 8 * k -: 8];
                end
            end
        end else if (!bad) begin
            if (r.size == lsu_pkg::SIZE_BYTE) begin
                b      = ref_mem[a];
                p.data = r.is_unsigned ? {24'h0, b} : {{24{b[7]}}, b};
            end else if (r.size == lsu_pkg::SIZE_HALF) begin
                h      = {ref_mem[a], ref_mem[a + 1]};
                p.data = r.is_unsigned ? {16'h0, h} : {{16{h[15]}}, h};
            end else begin
                for (int k = 0; k < 4; k++) begin
                    p.data = {p.data[23:0], ref_mem[a + k]};
                end
            end
        end
    endtask

    task automatic add_entry(input logic store, input lsu_pkg::lsu_size_t size,
                             input logic is_unsigned, input int addr,
                             input lsu_pkg::lsu_word_t data);
        entry_t e;
        e.req.store       = store;
        e.req.size        = size;
        e.req.is_unsigned = is_unsigned;
        e.req.addr        = lsu_pkg::lsu_addr_t'(addr);
        if (data == 32'h0) begin
            rng        = xorshift32(rng);   // zero means pick a random word.
            e.req.data = rng;
        end else begin
            e.req.data = data;
        end
        model_access(e.req, e.rsp);
        stim_table.push_back(e);
    endtask

    // responses are taken under random back-pressure and checked in order.
    initial begin
        lsu_pkg::lsu_rsp_t want;
        wait (rst === 1'b0);
        forever begin
            @(negedge CLK);
            rng       = xorshift32(rng);
            rsp_ready = (rng[1:0] != 2'b00);
            if (rsp_valid && rsp_ready) begin
                if (expect_q.size() == 0) begin
                    $display("response seen with no accepted request outstanding");
                    protocol_errors++;
                end else begin
                    want = expect_q.pop_front();
                    check_value("rsp.store", 32'(want.store), 32'(rsp.store));
                    check_value("rsp.misaligned", 32'(want.misaligned), 32'(rsp.misaligned));
                    check_value("rsp.data", want.data, rsp.data);
                end
                received++;
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d responses received",
                     cycles, received, stim_table.size());
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] pick;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;

        // word store, then word, byte and halfword loads.
        add_entry(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 'h10, 32'h11223344);
        add_entry(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 'h10, 32'h0);
        for (int i = 0; i < 4; i++) begin
            add_entry(1'b0, lsu_pkg::SIZE_BYTE, 1'b1, 'h10 + i, 32'h0);
        end
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 'h10, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 'h12, 32'h0);

        // byte stores into a filled word must leave the neighbours alone.
        add_entry(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 'h20, 32'ha5a5a5a5);
        for (int i = 0; i < 4; i++) begin
            add_entry(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, 'h20 + i, 32'h01 + i);
            add_entry(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 'h20, 32'h0);
        end

        // sign and zero extension.
        add_entry(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 'h30, 32'h80f27f81);
        add_entry(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, 'h30, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_BYTE, 1'b1, 'h30, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, 'h33, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, 'h32, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b0, 'h30, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 'h30, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b0, 'h32, 32'h0);
        add_entry(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 'h34, 32'h0000c3d4);
        add_entry(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 'h36, 32'h00009abc);
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b0, 'h36, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 'h34, 32'h0);

        // misaligned accesses leave memory alone.
        add_entry(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 'h11, 32'hdeadbeef);
        add_entry(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 'h12, 32'hdeadbeef);
        add_entry(1'b1, 2'd3, 1'b0, 'h10, 32'hdeadbeef);
        add_entry(1'b0, lsu_pkg::SIZE_HALF, 1'b0, 'h13, 32'h0);
        add_entry(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 'h10, 32'h0);

        // random traffic over a prefilled region.
        for (int i = 0; i < 16; i++) begin
            add_entry(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 'h40 + 4 * i, 32'h0);
        end
        for (int i = 0; i < 40; i++) begin
            rng  = xorshift32(rng);
            pick = rng;
            add_entry(pick[12], pick[9:8], pick[13], 'h40 + pick[5:0], 32'h0);
        end

        cycle_limit = stim_table.size() * 12 + 100;

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        // empty pipeline right out of reset.
        check_value("req_ready", 32'h1, 32'(req_ready));
        check_value("rsp_valid", 32'h0, 32'(rsp_valid));

        for (int i = 0; i < stim_table.size(); i++) begin
            @(negedge CLK);
            req_valid = 1'b1;
            req       = stim_table[i].req;
            while (!req_ready) begin
                @(negedge CLK);
            end
            @(posedge CLK);   // transfer on this edge.
            expect_q.push_back(stim_table[i].rsp);
            accepted++;
        end
        @(negedge CLK);
        req_valid = 1'b0;
        req       = '0;

        while (received < stim_table.size()) begin
            @(negedge CLK);
        end
        repeat (20) @(negedge CLK);   // any extra response shows up here.
        if (expect_q.size() != 0 || received != accepted) begin
            $display("response count does not match the %0d accepted requests", accepted);
            protocol_errors++;
        end

        $display("errors: %0d value, %0d protocol, %0d responses checked",
                 value_errors, protocol_errors, received);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
lsu_pkg.sv
lsu_align.sv
lsu_byte_memory.sv
lsu_load_format.sv
lsu_top.sv
lsu_tb.sv
